// ==== hdl/dma_rd_pkg.sv ====
//----------------------------
// Shared widths, types and shell constants for the DMA read-return
// multiplier. Every RTL file takes what it needs from here.
//----------------------------

`default_nettype none

package dma_rd_pkg;

   //----------------------------
   // Datapath widths
   //----------------------------
   localparam int DATA_W = 512;
   localparam int LANES  = 8;
   localparam int LANE_W = 32;
   localparam int PROD_W = 64;
   localparam int ID_W   = 6;
   localparam int RESP_W = 2;

   // Memory-ready bits reported in the status word
   localparam int NUM_DDR = 4;

   // Cycles the datapath stays in reset after the shell releases it
   localparam int RST_SLICE_STAGES = 4;

   //----------------------------
   // Types
   //----------------------------
   typedef logic [DATA_W-1:0]  rdata_t;
   typedef logic [LANE_W-1:0]  lane_t;
   typedef logic [PROD_W-1:0]  prod_t;
   typedef logic [ID_W-1:0]    rid_t;
   typedef logic [RESP_W-1:0]  resp_t;
   typedef logic [31:0]        reg32_t;
   typedef logic [NUM_DDR-1:0] ddr_ready_t;

   //----------------------------
   // Shell constants
   //----------------------------
   // Fixed upper field of status0
   localparam logic [19:0] STATUS_TAG = 20'hA1111;

   // Identification words read by the shell
   localparam reg32_t CL_VERSION = 32'hEEEE_EE00;
   localparam reg32_t CL_ID0     = 32'hC0DE_1234;
   localparam reg32_t CL_ID1     = 32'h0001_5A5A;

endpackage

`default_nettype wire

// ==== hdl/reset_slice.sv ====
//----------------------------
// Holds the datapath in reset for a few cycles after the shell
// reset is released. Assertion passes through at once.
//----------------------------

`default_nettype none
`timescale 1ns/10ps

module reset_slice
(
   input  wire  clk,
   input  wire  sync_rst_n,
   output logic slice_rst_n
);

   import dma_rd_pkg::*;

   logic [RST_SLICE_STAGES-1:0] slice_q;

   // Ones shift in from the bottom once reset is gone
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         slice_q <= '0;
      end
      else
      begin
         slice_q <= {slice_q[RST_SLICE_STAGES-2:0], 1'b1};
      end
   end

   assign slice_rst_n = slice_q[RST_SLICE_STAGES-1];

endmodule

`default_nettype wire

// ==== hdl/shell_status.sv ====
//----------------------------
// Shell-facing housekeeping: function-level-reset acknowledge,
// tagged status word and the identification words.
// Runs on the shell reset, not on the sliced datapath reset.
//----------------------------

`default_nettype none
`timescale 1ns/10ps

module shell_status
(
   input  wire                     clk,
   input  wire                     sync_rst_n,

   input  wire                     flr_assert,
   output logic                    flr_done,

   input  wire dma_rd_pkg::ddr_ready_t ddr_ready,

   output dma_rd_pkg::reg32_t      status0,
   output dma_rd_pkg::reg32_t      status1,
   output dma_rd_pkg::reg32_t      id0,
   output dma_rd_pkg::reg32_t      id1
);

   import dma_rd_pkg::*;

   logic       flr_assert_q;
   ddr_ready_t ddr_ready_q;

   //----------------------------
   // FLR acknowledge
   //----------------------------
   // A held request makes the done strobe toggle every cycle
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

   //----------------------------
   // Status and id words
   //----------------------------
   // Tag, hex F, scrub-done field (always zero), memory-ready bits
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ddr_ready_q <= '0;
         status0     <= '0;
      end
      else
      begin
         ddr_ready_q <= ddr_ready;
         status0     <= {STATUS_TAG, 4'hF, 4'b0000, ddr_ready_q};
      end
   end

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         id0 <= '0;
         id1 <= '0;
      end
      else
      begin
         id0 <= CL_ID0;
         id1 <= CL_ID1;
      end
   end

   assign status1 = CL_VERSION;

endmodule

`default_nettype wire

// ==== hdl/rd_beat_capture.sv ====
//----------------------------
// First pipeline stage. Registers a read beat from the memory side
// with its id, last and response. Holds while advance is low.
//----------------------------

`default_nettype none
`timescale 1ns/10ps

module rd_beat_capture
(
   input  wire                     clk,
   input  wire                     slice_rst_n,

   input  wire                     mem_rvalid,
   input  wire dma_rd_pkg::rdata_t mem_rdata,
   input  wire dma_rd_pkg::rid_t   mem_rid,
   input  wire                     mem_rlast,
   input  wire dma_rd_pkg::resp_t  mem_rresp,

   input  wire                     advance,

   output logic                    cap_valid,
   output dma_rd_pkg::rdata_t      cap_rdata,
   output dma_rd_pkg::rid_t        cap_rid,
   output logic                    cap_rlast,
   output dma_rd_pkg::resp_t       cap_rresp
);

   // Valid is the only control state here
   always_ff @(posedge clk or negedge slice_rst_n)
   begin
      if (!slice_rst_n)
      begin
         cap_valid <= 1'b0;
      end
      else if (advance)
      begin
         cap_valid <= mem_rvalid;
      end
   end

   // Payload follows the same enable
   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         cap_rdata <= mem_rdata;
         cap_rid   <= mem_rid;
         cap_rlast <= mem_rlast;
         cap_rresp <= mem_rresp;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/lane_mult_stage.sv ====
//----------------------------
// Second pipeline stage. Multiplies the upper by the lower word of
// each 64-bit lane and registers the products in reversed lane
// order. Owns the stall decision for the whole pipeline.
//----------------------------

`default_nettype none
`timescale 1ns/10ps

module lane_mult_stage
(
   input  wire                     clk,
   input  wire                     slice_rst_n,

   input  wire                     cap_valid,
   input  wire dma_rd_pkg::rdata_t cap_rdata,
   input  wire dma_rd_pkg::rid_t   cap_rid,
   input  wire                     cap_rlast,
   input  wire dma_rd_pkg::resp_t  cap_rresp,

   input  wire                     host_rready,
   output logic                    advance,

   output logic                    host_rvalid,
   output dma_rd_pkg::rdata_t      host_rdata,
   output dma_rd_pkg::rid_t        host_rid,
   output logic                    host_rlast,
   output dma_rd_pkg::resp_t       host_rresp
);

   import dma_rd_pkg::*;

   rdata_t prod_packed;

   // Unsigned 32x32 product, zero extended before the multiply
   function automatic prod_t lane_product(input lane_t hi, input lane_t lo);
      return prod_t'(hi) * prod_t'(lo);
   endfunction

   //----------------------------
   // Lane multipliers
   //----------------------------
   // Lane k lands in output field LANES-1-k
   always_comb
   begin
      prod_packed = '0;
      for (int k = 0; k < LANES; k++)
      begin
         prod_packed[(LANES-1-k)*PROD_W +: PROD_W] =
            lane_product(cap_rdata[k*PROD_W+LANE_W +: LANE_W],
                         cap_rdata[k*PROD_W +: LANE_W]);
      end
   end

   //----------------------------
   // Output register
   //----------------------------
   // Move when empty or when the host takes the current beat
   assign advance = !host_rvalid || host_rready;

   always_ff @(posedge clk or negedge slice_rst_n)
   begin
      if (!slice_rst_n)
      begin
         host_rvalid <= 1'b0;
      end
      else if (advance)
      begin
         host_rvalid <= cap_valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         host_rdata <= prod_packed;
         host_rid   <= cap_rid;
         host_rlast <= cap_rlast;
         host_rresp <= cap_rresp;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/dma_rd_mult_top.sv ====
//----------------------------
// Top of the DMA read-return multiplier. Connects the reset slice,
// the shell status block and the two pipeline stages.
// Read beats enter on mem_r* and leave, multiplied, on host_r*.
//----------------------------

`default_nettype none
`timescale 1ns/10ps

module dma_rd_mult_top
(
   input  wire                         clk,
   input  wire                         sync_rst_n,

   // Memory side of the read return
   input  wire                         mem_rvalid,
   input  wire dma_rd_pkg::rdata_t     mem_rdata,
   input  wire dma_rd_pkg::rid_t       mem_rid,
   input  wire                         mem_rlast,
   input  wire dma_rd_pkg::resp_t      mem_rresp,
   output logic                        mem_rready,

   // Host side of the read return
   output logic                        host_rvalid,
   output dma_rd_pkg::rdata_t          host_rdata,
   output dma_rd_pkg::rid_t            host_rid,
   output logic                        host_rlast,
   output dma_rd_pkg::resp_t           host_rresp,
   input  wire                         host_rready,

   // Shell housekeeping
   input  wire                         flr_assert,
   output logic                        flr_done,
   input  wire dma_rd_pkg::ddr_ready_t ddr_ready,
   output dma_rd_pkg::reg32_t          status0,
   output dma_rd_pkg::reg32_t          status1,
   output dma_rd_pkg::reg32_t          id0,
   output dma_rd_pkg::reg32_t          id1
);

   import dma_rd_pkg::*;

   logic   slice_rst_n;
   logic   advance;

   logic   cap_valid;
   rdata_t cap_rdata;
   rid_t   cap_rid;
   logic   cap_rlast;
   resp_t  cap_rresp;

   //----------------------------
   // Reset and shell status
   //----------------------------
   reset_slice u_reset_slice
   (
      .clk         (clk),
      .sync_rst_n  (sync_rst_n),
      .slice_rst_n (slice_rst_n)
   );

   shell_status u_shell_status
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .flr_assert (flr_assert),
      .flr_done   (flr_done),
      .ddr_ready  (ddr_ready),
      .status0    (status0),
      .status1    (status1),
      .id0        (id0),
      .id1        (id1)
   );

   //----------------------------
   // Read-return pipeline
   //----------------------------
   // No beats accepted until the datapath is out of reset
   assign mem_rready = advance && slice_rst_n;

   rd_beat_capture u_rd_beat_capture
   (
      .clk         (clk),
      .slice_rst_n (slice_rst_n),
      .mem_rvalid  (mem_rvalid),
      .mem_rdata   (mem_rdata),
      .mem_rid     (mem_rid),
      .mem_rlast   (mem_rlast),
      .mem_rresp   (mem_rresp),
      .advance     (advance),
      .cap_valid   (cap_valid),
      .cap_rdata   (cap_rdata),
      .cap_rid     (cap_rid),
      .cap_rlast   (cap_rlast),
      .cap_rresp   (cap_rresp)
   );

   lane_mult_stage u_lane_mult_stage
   (
      .clk         (clk),
      .slice_rst_n (slice_rst_n),
      .cap_valid   (cap_valid),
      .cap_rdata   (cap_rdata),
      .cap_rid     (cap_rid),
      .cap_rlast   (cap_rlast),
      .cap_rresp   (cap_rresp),
      .host_rready (host_rready),
      .advance     (advance),
      .host_rvalid (host_rvalid),
      .host_rdata  (host_rdata),
      .host_rid    (host_rid),
      .host_rlast  (host_rlast),
      .host_rresp  (host_rresp)
   );

endmodule

`default_nettype wire

// ==== verif/tb_dma_rd_mult.sv ====
//----------------------------
// Testbench for the DMA read-return multiplier. Runs a table of
// read bursts through the DUT and checks the lane products, order,
// latency and stall behavior. Also checks the FLR acknowledge and
// the status and id words.
//----------------------------

`default_nettype none
`timescale 1ns/10ps

module tb_dma_rd_mult;

   import dma_rd_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int NUM_TESTS  = 6;

   // Lane pattern kinds
   localparam int PAT_ZERO = 0;
   localparam int PAT_ONES = 1;
   localparam int PAT_RAND = 2;
   localparam int PAT_WALK = 3;

   // FLR request modes
   localparam int FLR_NONE  = 0;
   localparam int FLR_PULSE = 1;
   localparam int FLR_HELD  = 2;

   typedef struct {
      int         beats;
      int         kind;
      rid_t       id;
      logic       last;
      resp_t      resp;
      int         stalls;
      ddr_ready_t ddr;
      int         flr;
   } test_t;

   typedef struct {
      rdata_t data;
      rid_t   id;
      logic   last;
      resp_t  resp;
      int     cyc;
      logic   chk_lat;
   } exp_beat_t;

   logic       clk;
   logic       sync_rst_n;
   logic       mem_rvalid;
   rdata_t     mem_rdata;
   rid_t       mem_rid;
   logic       mem_rlast;
   resp_t      mem_rresp;
   logic       mem_rready;
   logic       host_rvalid;
   rdata_t     host_rdata;
   rid_t       host_rid;
   logic       host_rlast;
   resp_t      host_rresp;
   logic       host_rready;
   logic       flr_assert;
   logic       flr_done;
   ddr_ready_t ddr_ready;
   reg32_t     status0;
   reg32_t     status1;
   reg32_t     id0;
   reg32_t     id1;

   test_t      tests[NUM_TESTS];
   exp_beat_t  exp_q[$];
   int         errors      = 0;
   int         beats_out   = 0;
   int         cycle       = 0;
   int         stall_limit = 0;
   int         stall_used  = 0;
   logic       lat_check   = 1'b0;

   dma_rd_mult_top DUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   initial
   begin
      forever
      begin
         @(posedge clk);
         cycle <= cycle + 1;
      end
   end

   //----------------------------
   // Helpers
   //----------------------------
   task automatic check_val(input string name, input rdata_t expected, input rdata_t actual);
      if (actual !== expected)
      begin
         $display("[ERROR] %0t %s: expected %0h, got %0h", $time, name, expected, actual);
         errors++;
      end
   endtask

   // Upper word times lower word of lane k goes to field 7-k
   function automatic rdata_t expected_beat(input rdata_t beat);
      rdata_t      res;
      logic [63:0] lane;
      for (int k = 0; k < 8; k++)
      begin
         lane = beat[64*k +: 64];
         res[64*(7-k) +: 64] = {32'b0, lane[63:32]} * {32'b0, lane[31:0]};
      end
      return res;
   endfunction

   function automatic reg32_t status_word(input ddr_ready_t ddr);
      return {STATUS_TAG, 4'hF, 4'h0, ddr};
   endfunction

   // Walking one moves through each 32-bit word with an offset per word
   function automatic rdata_t make_pattern(input int kind, input int b);
      rdata_t pat;
      pat = '0;
      for (int w = 0; w < DATA_W/LANE_W; w++)
      begin
         case (kind)
            PAT_ONES: pat[w*LANE_W +: LANE_W] = '1;
            PAT_RAND: pat[w*LANE_W +: LANE_W] = $urandom;
            PAT_WALK: pat[w*LANE_W + (b + 3*w) % LANE_W] = 1'b1;
            default:  pat[w*LANE_W +: LANE_W] = '0;
         endcase
      end
      return pat;
   endfunction

   // beats, kind, id, last, resp, stall budget, ddr_ready, flr mode
   task automatic load_table();
      tests[0] = '{4,  PAT_ZERO, 6'h01, 1'b1, 2'd0, 0,  4'h0, FLR_PULSE};
      tests[1] = '{4,  PAT_ONES, 6'h02, 1'b1, 2'd1, 0,  4'h5, FLR_NONE};
      tests[2] = '{16, PAT_RAND, 6'h03, 1'b1, 2'd0, 0,  4'hA, FLR_HELD};
      tests[3] = '{8,  PAT_WALK, 6'h2A, 1'b0, 2'd2, 0,  4'hF, FLR_PULSE};
      tests[4] = '{24, PAT_RAND, 6'h3F, 1'b1, 2'd3, 30, 4'h3, FLR_NONE};
      tests[5] = '{12, PAT_WALK, 6'h05, 1'b1, 2'd0, 15, 4'hC, FLR_PULSE};
   endtask

   task automatic drive_beat(input int t, input int b);
      mem_rvalid <= 1'b1;
      mem_rdata  <= make_pattern(tests[t].kind, b);
      mem_rid    <= tests[t].id;
      mem_rlast  <= tests[t].last && (b == tests[t].beats - 1);
      mem_rresp  <= tests[t].resp;
   endtask

   // Offers each beat until mem_rready takes it
   task automatic send_beats(input int t);
      int   b;
      logic acc;
      b = 0;
      @(posedge clk);
      drive_beat(t, 0);
      while (b < tests[t].beats)
      begin
         @(negedge clk);
         acc = mem_rready;
         @(posedge clk);
         if (acc)
         begin
            b++;
            if (b < tests[t].beats)
               drive_beat(t, b);
            else
               mem_rvalid <= 1'b0;
         end
      end
   endtask

   // New ddr_ready and FLR request at edge E show after E+2
   task automatic shell_step(input int t);
      ddr_ready_t old_ddr;
      int         n;
      logic       exp_done;
      old_ddr = ddr_ready;
      n = (tests[t].flr == FLR_HELD) ? 6 : 2;
      @(posedge clk);
      ddr_ready  <= tests[t].ddr;
      flr_assert <= (tests[t].flr != FLR_NONE);
      @(posedge clk);
      if (tests[t].flr == FLR_PULSE)
         flr_assert <= 1'b0;
      @(negedge clk);
      check_val("flr_done", rdata_t'(1'b0), rdata_t'(flr_done));
      check_val("status0", rdata_t'(status_word(old_ddr)), rdata_t'(status0));
      for (int i = 0; i < n; i++)
      begin
         @(negedge clk);
         if (tests[t].flr == FLR_HELD)
            exp_done = (i % 2 == 0);
         else
            exp_done = (tests[t].flr == FLR_PULSE) && (i == 0);
         check_val("flr_done", rdata_t'(exp_done), rdata_t'(flr_done));
         check_val("status0", rdata_t'(status_word(tests[t].ddr)), rdata_t'(status0));
      end
      check_val("status1", rdata_t'(CL_VERSION), rdata_t'(status1));
      check_val("id0", rdata_t'(CL_ID0), rdata_t'(id0));
      check_val("id1", rdata_t'(CL_ID1), rdata_t'(id1));
      @(posedge clk);
      flr_assert <= 1'b0;
      repeat (3) @(posedge clk);
   endtask

   //----------------------------
   // Host back-pressure and output monitor
   //----------------------------
   initial
   begin
      host_rready = 1'b1;
      forever
      begin
         @(posedge clk);
         if (stall_used < stall_limit && ($urandom % 2) == 0)
         begin
            host_rready <= 1'b0;
            stall_used  = stall_used + 1;
         end
         else
         begin
            host_rready <= 1'b1;
         end
      end
   end

   initial
   begin
      exp_beat_t e;
      logic      held;
      rdata_t    held_data;
      rid_t      held_id;
      logic      held_last;
      resp_t     held_resp;
      held = 1'b0;
      forever
      begin
         @(negedge clk);
         // Beat taken at the coming edge
         if (mem_rvalid && mem_rready)
         begin
            e.data    = expected_beat(mem_rdata);
            e.id      = mem_rid;
            e.last    = mem_rlast;
            e.resp    = mem_rresp;
            e.cyc     = cycle;
            e.chk_lat = lat_check;
            exp_q.push_back(e);
         end
         if (held)
         begin
            check_val("host_rvalid", rdata_t'(1'b1), rdata_t'(host_rvalid));
            check_val("host_rdata", held_data, host_rdata);
            check_val("host_rid", rdata_t'(held_id), rdata_t'(host_rid));
            check_val("host_rlast", rdata_t'(held_last), rdata_t'(host_rlast));
            check_val("host_rresp", rdata_t'(held_resp), rdata_t'(host_rresp));
         end
         if (host_rvalid && !host_rready)
            check_val("mem_rready", rdata_t'(1'b0), rdata_t'(mem_rready));
         if (host_rvalid && host_rready)
         begin
            if (exp_q.size() == 0)
            begin
               $display("%0t: host beat came out with no accepted beat left for it", $time);
               errors++;
            end
            else
            begin
               e = exp_q.pop_front();
               check_val("host_rdata", e.data, host_rdata);
               check_val("host_rid", rdata_t'(e.id), rdata_t'(host_rid));
               check_val("host_rlast", rdata_t'(e.last), rdata_t'(host_rlast));
               check_val("host_rresp", rdata_t'(e.resp), rdata_t'(host_rresp));
               if (e.chk_lat)
                  check_val("latency", rdata_t'(e.cyc + 2), rdata_t'(cycle));
               beats_out++;
            end
         end
         held      = host_rvalid && !host_rready;
         held_data = host_rdata;
         held_id   = host_rid;
         held_last = host_rlast;
         held_resp = host_rresp;
      end
   end

   //----------------------------
   // Main sequence
   //----------------------------
   initial
   begin
      int          t;
      int          err0;
      int          low;
      int          fails;
      int unsigned seed;
      $timeformat(-9, 0, " ns", 0);
      seed = $urandom(32'ha0a1);
      load_table();
      fails      = 0;
      sync_rst_n = 1'b0;
      mem_rvalid = 1'b0;
      mem_rdata  = '0;
      mem_rid    = '0;
      mem_rlast  = 1'b0;
      mem_rresp  = '0;
      flr_assert = 1'b0;
      ddr_ready  = '0;
      repeat (7) @(posedge clk);
      @(negedge clk);
      check_val("mem_rready", rdata_t'(1'b0), rdata_t'(mem_rready));
      check_val("host_rvalid", rdata_t'(1'b0), rdata_t'(host_rvalid));
      @(posedge clk);
      sync_rst_n <= 1'b1;

      // Datapath stays closed while the reset slice fills
      low = 0;
      @(negedge clk);
      while (!mem_rready && low < 4 * RST_SLICE_STAGES)
      begin
         check_val("host_rvalid", rdata_t'(1'b0), rdata_t'(host_rvalid));
         low++;
         @(negedge clk);
      end
      err0 = errors;
      check_val("reset release cycles", rdata_t'(RST_SLICE_STAGES), rdata_t'(low));
      if (errors != err0)
         fails++;
      $display("test reset: %0d cycles before mem_rready, %s", low,
               (errors == err0) ? "ok" : "bad");

      for (t = 0; t < NUM_TESTS; t++)
      begin
         err0 = errors;
         shell_step(t);
         @(negedge clk);
         lat_check   = (tests[t].stalls == 0);
         stall_limit = stall_used + tests[t].stalls;
         send_beats(t);
         while (exp_q.size() != 0)
            @(posedge clk);
         @(negedge clk);
         stall_limit = stall_used;
         if (errors != err0)
            fails++;
         $display("test %0d: %0d beats, %0d errors, %s", t, tests[t].beats,
                  errors - err0, (errors == err0) ? "ok" : "bad");
      end

      $display("%0d tests, %0d failing, %0d beats checked, %0d errors",
               NUM_TESTS + 1, fails, beats_out, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   // Limit grows with the beats, stalls and shell steps of each test
   initial
   begin
      int limit;
      #1;
      limit = 8 + 4 * RST_SLICE_STAGES + 20;
      for (int t = 0; t < NUM_TESTS; t++)
         limit = limit + tests[t].beats + tests[t].stalls + 30;
      limit = limit * 4;
      #(limit * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d clock periods", limit);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/dma_rd_pkg.sv
hdl/reset_slice.sv
hdl/shell_status.sv
hdl/rd_beat_capture.sv
hdl/lane_mult_stage.sv
hdl/dma_rd_mult_top.sv
verif/tb_dma_rd_mult.sv

// ==== Makefile ====
# Verilator build and run of the DMA read-return multiplier testbench

TOP := tb_dma_rd_mult
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f hdl/*.sv verif/*.sv
	verilator --binary --timing -j 0 --top-module $(TOP) -f files.f -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "No pass message in $(LOG)"; exit 1; }

lint:
	verilator --lint-only -Wall --top-module dma_rd_mult_top \
		hdl/dma_rd_pkg.sv hdl/reset_slice.sv hdl/shell_status.sv \
		hdl/rd_beat_capture.sv hdl/lane_mult_stage.sv hdl/dma_rd_mult_top.sv

clean:
	rm -rf obj_dir $(LOG)
